//--- source/pico_l15_pkg.sv
/*
  pico to l1.5 bridge definitions
  interface widths, request, size and return codes, shared structs
*/
`default_nettype none

package pico_l15_pkg;

    // interface widths
    localparam int CORE_ADDR_W = 32;
    localparam int L15_ADDR_W  = 40;
    localparam int WORD_W      = 32;
    localparam int DWORD_W     = 64;
    localparam int WSTRB_W     = 4;
    localparam int AMO_OP_W    = 4;
    localparam int RQTYPE_W    = 5;
    localparam int SIZE_W      = 3;
    localparam int RETTYPE_W   = 4;

    typedef logic [CORE_ADDR_W-1:0] addr32_t;
    typedef logic [L15_ADDR_W-1:0]  addr40_t;
    typedef logic [WORD_W-1:0]      word_t;
    typedef logic [DWORD_W-1:0]     dword_t;
    typedef logic [WSTRB_W-1:0]     wstrb_t;
    typedef logic [AMO_OP_W-1:0]    amo_op_t;
    typedef logic [RQTYPE_W-1:0]    rqtype_t;
    typedef logic [SIZE_W-1:0]      size_t;
    typedef logic [RETTYPE_W-1:0]   rettype_t;

    // atomic opcode for plain loads and stores
    localparam amo_op_t AMO_OP_NONE = '0;

    // l1.5 request types
    localparam rqtype_t RQ_LOAD  = 5'b00000;
    localparam rqtype_t RQ_STORE = 5'b00001;
    localparam rqtype_t RQ_AMO   = 5'b00110;

    // access sizes, zero is left for an illegal strobe pattern
    localparam size_t SZ_1B = 3'b001;
    localparam size_t SZ_2B = 3'b010;
    localparam size_t SZ_4B = 3'b011;

    // l1.5 return types
    localparam rettype_t RET_LOAD      = 4'b0000;
    localparam rettype_t RET_STORE_ACK = 4'b0100;
    localparam rettype_t RET_AMO       = 4'b1110;

    // decoder wait machine
    typedef enum logic {
        ACK_IDLE,
        ACK_WAIT
    } ack_state_e;

    // kind of the request in flight
    typedef enum logic [1:0] {
        KIND_NONE,
        KIND_LOAD,
        KIND_STORE,
        KIND_AMO
    } req_kind_e;

    typedef struct packed {
        rqtype_t rqtype;
        amo_op_t amo_op;
        size_t   size;
        addr40_t address;
        dword_t  data;
        logic    nc;
    } l15_req_t;

    typedef struct packed {
        rettype_t rettype;
        dword_t   data;
    } l15_ret_t;

    // core is little endian, the l1.5 beat is big endian
    function automatic word_t swap_bytes(input word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

endpackage

`default_nettype wire

//--- source/pico_request_decoder.sv
/*
  request decoder
  turns a core memory request into one l1.5 load, store or atomic
  and holds the request valid until the cache acks it
*/
`default_nettype none

module pico_request_decoder (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         mem_valid,
    input  wire pico_l15_pkg::addr32_t  mem_addr,
    input  wire pico_l15_pkg::wstrb_t   mem_wstrb,
    input  wire pico_l15_pkg::word_t    mem_wdata,
    input  wire pico_l15_pkg::amo_op_t  mem_amo_op,
    input  wire                         l15_ack,
    // header ack is not needed, the full ack ends the wait
    input  wire                         l15_header_ack,
    output logic                        new_request,
    output logic                        l15_val,
    output pico_l15_pkg::l15_req_t      l15_req
);

    localparam int EXT_W = pico_l15_pkg::L15_ADDR_W - pico_l15_pkg::CORE_ADDR_W;

    logic                     valid_q;
    logic                     valid_qq;
    pico_l15_pkg::ack_state_e state;
    pico_l15_pkg::ack_state_e state_next;
    pico_l15_pkg::word_t      wdata_swapped;
    logic                     is_store;
    logic                     is_amo;

    // two stage history of the core valid
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q  <= 1'b0;
            valid_qq <= 1'b0;
        end else begin
            valid_q  <= mem_valid;
            valid_qq <= valid_q;
        end
    end

    // rising edge of the registered valid marks a fresh request
    assign new_request = valid_q & ~valid_qq;

    // ack wins over a new request in the same cycle
    always_comb begin
        state_next = state;
        if (l15_ack) begin
            state_next = pico_l15_pkg::ACK_IDLE;
        end else if (new_request) begin
            state_next = pico_l15_pkg::ACK_WAIT;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= pico_l15_pkg::ACK_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // idle: only the new request pulse
    // waiting: keep valid up as long as the core does
    assign l15_val = (state == pico_l15_pkg::ACK_WAIT) ? mem_valid : new_request;

    // any strobe means a write, amo opcode turns it into an atomic
    assign is_store = |mem_wstrb;
    assign is_amo   = is_store && (mem_amo_op != pico_l15_pkg::AMO_OP_NONE);

    assign wdata_swapped = pico_l15_pkg::swap_bytes(mem_wdata);

    // request fields, all zero while the core is idle
    always_comb begin
        l15_req = '0;
        if (mem_valid) begin
            l15_req.amo_op  = mem_amo_op;
            // sign extend into the 40 bit space
            l15_req.address = {{EXT_W{mem_addr[pico_l15_pkg::CORE_ADDR_W-1]}}, mem_addr};
            // upper half of the space is io, atomics bypass the cache too
            l15_req.nc      = mem_addr[pico_l15_pkg::CORE_ADDR_W-1] | is_amo;
            if (is_store) begin
                l15_req.rqtype = is_amo ? pico_l15_pkg::RQ_AMO : pico_l15_pkg::RQ_STORE;
                // word copied into both halves, the cache picks by address
                l15_req.data   = {wdata_swapped, wdata_swapped};
                case (mem_wstrb)
                    4'b1111: begin
                        l15_req.size = pico_l15_pkg::SZ_4B;
                    end
                    4'b1100, 4'b0011: begin
                        l15_req.size = pico_l15_pkg::SZ_2B;
                    end
                    4'b1000, 4'b0100, 4'b0010, 4'b0001: begin
                        l15_req.size = pico_l15_pkg::SZ_1B;
                    end
                    default: begin
                        // unaligned or split strobes, not a legal access
                        l15_req.size = '0;
                    end
                endcase
            end else begin
                // loads always fetch the full word
                l15_req.rqtype = pico_l15_pkg::RQ_LOAD;
                l15_req.size   = pico_l15_pkg::SZ_4B;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/pico_request_tracker.sv
/*
  request tracker
  keeps the kind and word lane of the single request in flight
*/
`default_nettype none

module pico_request_tracker (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          new_request,
    input  wire pico_l15_pkg::wstrb_t    mem_wstrb,
    input  wire pico_l15_pkg::amo_op_t   mem_amo_op,
    input  wire                          addr_bit2,
    input  wire                          mem_ready,
    output pico_l15_pkg::req_kind_e      kind,
    output logic                         lane_low
);

    pico_l15_pkg::req_kind_e kind_new;

    // same classification the decoder applies to the live inputs
    always_comb begin
        if (mem_wstrb == '0) begin
            kind_new = pico_l15_pkg::KIND_LOAD;
        end else if (mem_amo_op != pico_l15_pkg::AMO_OP_NONE) begin
            kind_new = pico_l15_pkg::KIND_AMO;
        end else begin
            kind_new = pico_l15_pkg::KIND_STORE;
        end
    end

    // kind lives from the new request until the core sees ready
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            kind <= pico_l15_pkg::KIND_NONE;
        end else if (new_request) begin
            kind <= kind_new;
        end else if (mem_ready) begin
            kind <= pico_l15_pkg::KIND_NONE;
        end
    end

    // address bit 2 set means the low half of the big endian beat
    always_ff @(posedge clk) begin
        if (new_request) begin
            lane_low <= addr_bit2;
        end
    end

endmodule

`default_nettype wire

//--- source/pico_response_encoder.sv
/*
  response encoder
  acks each l1.5 return at once and hands the core its read word
  together with a one cycle ready pulse
*/
`default_nettype none

module pico_response_encoder (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          ret_val,
    input  wire pico_l15_pkg::l15_ret_t  l15_ret,
    input  wire pico_l15_pkg::req_kind_e kind,
    input  wire                          lane_low,
    output logic                         ret_ack,
    output logic                         mem_ready,
    output pico_l15_pkg::word_t          mem_rdata
);

    pico_l15_pkg::word_t ret_word;
    pico_l15_pkg::word_t rdata_next;
    logic                has_data;

    // the bridge never stalls the return path
    assign ret_ack = ret_val;

    // loads and atomics carry data back, a store ack does not
    assign has_data = (kind == pico_l15_pkg::KIND_LOAD) ||
                      (kind == pico_l15_pkg::KIND_AMO);

    // pick the addressed word out of the 64 bit beat
    always_comb begin
        if (lane_low) begin
            ret_word = l15_ret.data[pico_l15_pkg::WORD_W-1:0];
        end else begin
            ret_word = l15_ret.data[pico_l15_pkg::DWORD_W-1:pico_l15_pkg::WORD_W];
        end
    end

    // back to core byte order, zero for stores
    always_comb begin
        if (has_data) begin
            rdata_next = pico_l15_pkg::swap_bytes(ret_word);
        end else begin
            rdata_next = '0;
        end
    end

    // ready follows the return by one cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_ready <= 1'b0;
        end else begin
            mem_ready <= ret_val;
        end
    end

    // read data lands together with ready and holds until the next return
    always_ff @(posedge clk) begin
        if (ret_val) begin
            mem_rdata <= rdata_next;
        end
    end

endmodule

`default_nettype wire

//--- source/pico_l15_bridge.sv
/*
  pico to l1.5 bridge top
  request decoder, in-flight tracker and response encoder
*/
`default_nettype none

module pico_l15_bridge (
    input  wire                          clk,
    input  wire                          rst_n,
    // core memory port
    input  wire                          mem_valid,
    input  wire pico_l15_pkg::addr32_t   mem_addr,
    input  wire pico_l15_pkg::wstrb_t    mem_wstrb,
    input  wire pico_l15_pkg::word_t     mem_wdata,
    input  wire pico_l15_pkg::amo_op_t   mem_amo_op,
    output logic                         mem_ready,
    output pico_l15_pkg::word_t          mem_rdata,
    // l1.5 request side
    output logic                         l15_val,
    output pico_l15_pkg::l15_req_t       l15_req,
    input  wire                          l15_ack,
    input  wire                          l15_header_ack,
    // l1.5 return side
    input  wire                          ret_val,
    input  wire pico_l15_pkg::l15_ret_t  l15_ret,
    output logic                         ret_ack
);

    logic                    new_request;
    pico_l15_pkg::req_kind_e kind;
    logic                    lane_low;

    pico_request_decoder u_decoder (
        .clk            (clk),
        .rst_n          (rst_n),
        .mem_valid      (mem_valid),
        .mem_addr       (mem_addr),
        .mem_wstrb      (mem_wstrb),
        .mem_wdata      (mem_wdata),
        .mem_amo_op     (mem_amo_op),
        .l15_ack        (l15_ack),
        .l15_header_ack (l15_header_ack),
        .new_request    (new_request),
        .l15_val        (l15_val),
        .l15_req        (l15_req)
    );

    // only address bit 2 matters once the request is accepted
    pico_request_tracker u_tracker (
        .clk         (clk),
        .rst_n       (rst_n),
        .new_request (new_request),
        .mem_wstrb   (mem_wstrb),
        .mem_amo_op  (mem_amo_op),
        .addr_bit2   (mem_addr[2]),
        .mem_ready   (mem_ready),
        .kind        (kind),
        .lane_low    (lane_low)
    );

    pico_response_encoder u_encoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .ret_val   (ret_val),
        .l15_ret   (l15_ret),
        .kind      (kind),
        .lane_low  (lane_low),
        .ret_ack   (ret_ack),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata)
    );

endmodule

`default_nettype wire

//--- sim/tb_vectors.svh
/*
  request and return table for the bridge testbench
  one add_row call per core access, with the cache timing and the expected results
*/

// columns: mem_addr, mem_wstrb, mem_wdata, mem_amo_op, ack delay, return delay, return data,
//          then expected rqtype, size, address, data, nc and mem_rdata
task automatic load_table();
    // loads, the word lane follows address bit 2
    add_row(32'h0000_1000, 4'b0000, 32'hdead_beef, 4'h0, 0, 0, 64'h1122_3344_5566_7788,
            pico_l15_pkg::RQ_LOAD, pico_l15_pkg::SZ_4B, 40'h00_0000_1000,
            64'h0, 1'b0, 32'h4433_2211);
    add_row(32'h0000_2004, 4'b0000, 32'h0000_0000, 4'h0, 2, 3, 64'h0102_0304_a1b2_c3d4,
            pico_l15_pkg::RQ_LOAD, pico_l15_pkg::SZ_4B, 40'h00_0000_2004,
            64'h0, 1'b0, 32'hd4c3_b2a1);
    // upper half of the space is io, sign extended and non-cacheable
    add_row(32'h8000_0010, 4'b0000, 32'h0000_0000, 4'h0, 1, 5, 64'hcafe_f00d_0bad_beef,
            pico_l15_pkg::RQ_LOAD, pico_l15_pkg::SZ_4B, 40'hff_8000_0010,
            64'h0, 1'b1, 32'h0df0_feca);
    add_row(32'hffff_fffc, 4'b0000, 32'h0000_0000, 4'h0, 4, 0, 64'h8899_aabb_ccdd_eeff,
            pico_l15_pkg::RQ_LOAD, pico_l15_pkg::SZ_4B, 40'hff_ffff_fffc,
            64'h0, 1'b1, 32'hffee_ddcc);
    // stores, every legal strobe shape
    add_row(32'h0000_0100, 4'b1111, 32'h1234_5678, 4'h0, 0, 1, 64'hffff_ffff_ffff_ffff,
            pico_l15_pkg::RQ_STORE, pico_l15_pkg::SZ_4B, 40'h00_0000_0100,
            64'h7856_3412_7856_3412, 1'b0, 32'h0);
    add_row(32'h0000_0104, 4'b0011, 32'h0000_abcd, 4'h0, 3, 2, 64'h5555_aaaa_5555_aaaa,
            pico_l15_pkg::RQ_STORE, pico_l15_pkg::SZ_2B, 40'h00_0000_0104,
            64'hcdab_0000_cdab_0000, 1'b0, 32'h0);
    add_row(32'h0000_0108, 4'b1100, 32'h5a5a_0000, 4'h0, 0, 0, 64'hffff_ffff_ffff_ffff,
            pico_l15_pkg::RQ_STORE, pico_l15_pkg::SZ_2B, 40'h00_0000_0108,
            64'h0000_5a5a_0000_5a5a, 1'b0, 32'h0);
    add_row(32'h0000_010c, 4'b0001, 32'h0000_0077, 4'h0, 1, 1, 64'h1234_5678_9abc_def0,
            pico_l15_pkg::RQ_STORE, pico_l15_pkg::SZ_1B, 40'h00_0000_010c,
            64'h7700_0000_7700_0000, 1'b0, 32'h0);
    add_row(32'h9000_0000, 4'b1000, 32'hee00_0000, 4'h0, 2, 0, 64'hffff_ffff_ffff_ffff,
            pico_l15_pkg::RQ_STORE, pico_l15_pkg::SZ_1B, 40'hff_9000_0000,
            64'h0000_00ee_0000_00ee, 1'b1, 32'h0);
    add_row(32'h0000_0200, 4'b0100, 32'h0033_0000, 4'h0, 0, 3, 64'h0f0f_0f0f_0f0f_0f0f,
            pico_l15_pkg::RQ_STORE, pico_l15_pkg::SZ_1B, 40'h00_0000_0200,
            64'h0000_3300_0000_3300, 1'b0, 32'h0);
    // split strobes have no legal size
    add_row(32'h0000_0300, 4'b0110, 32'h0102_0304, 4'h0, 1, 0, 64'hffff_ffff_ffff_ffff,
            pico_l15_pkg::RQ_STORE, 3'd0, 40'h00_0000_0300,
            64'h0403_0201_0403_0201, 1'b0, 32'h0);
    add_row(32'h0000_0304, 4'b1001, 32'hffff_0000, 4'h0, 0, 2, 64'hffff_ffff_ffff_ffff,
            pico_l15_pkg::RQ_STORE, 3'd0, 40'h00_0000_0304,
            64'h0000_ffff_0000_ffff, 1'b0, 32'h0);
    // atomics bypass the cache and return the old word
    add_row(32'h0000_0400, 4'b1111, 32'h0000_0001, 4'h3, 1, 2, 64'h0500_0000_0600_0000,
            pico_l15_pkg::RQ_AMO, pico_l15_pkg::SZ_4B, 40'h00_0000_0400,
            64'h0100_0000_0100_0000, 1'b1, 32'h0000_0005);
    add_row(32'h0000_0404, 4'b1111, 32'hffff_fff0, 4'h9, 5, 4, 64'h0000_0000_7856_3412,
            pico_l15_pkg::RQ_AMO, pico_l15_pkg::SZ_4B, 40'h00_0000_0404,
            64'hf0ff_ffff_f0ff_ffff, 1'b1, 32'h1234_5678);
endtask

//--- sim/tb_pico_l15_bridge.sv
/*
  testbench for the pico to l1.5 bridge
  plays the core and the l1.5 cache, checks requests, handshakes and returns
*/
`default_nettype none

module tb_pico_l15_bridge;

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        pico_l15_pkg::addr32_t addr;
        pico_l15_pkg::wstrb_t  wstrb;
        pico_l15_pkg::word_t   wdata;
        pico_l15_pkg::amo_op_t amo_op;
        logic [3:0]            ack_delay;
        logic [3:0]            ret_delay;
        pico_l15_pkg::dword_t  ret_data;
        pico_l15_pkg::rqtype_t exp_rqtype;
        pico_l15_pkg::size_t   exp_size;
        pico_l15_pkg::addr40_t exp_addr;
        pico_l15_pkg::dword_t  exp_data;
        logic                  exp_nc;
        pico_l15_pkg::word_t   exp_rdata;
    } row_t;

    localparam int RANDOM_ROWS = 8;

    logic                   clk;
    logic                   rst_n;
    logic                   mem_valid;
    pico_l15_pkg::addr32_t  mem_addr;
    pico_l15_pkg::wstrb_t   mem_wstrb;
    pico_l15_pkg::word_t    mem_wdata;
    pico_l15_pkg::amo_op_t  mem_amo_op;
    logic                   mem_ready;
    pico_l15_pkg::word_t    mem_rdata;
    logic                   l15_val;
    pico_l15_pkg::l15_req_t l15_req;
    logic                   l15_ack;
    logic                   l15_header_ack;
    logic                   ret_val;
    pico_l15_pkg::l15_ret_t l15_ret;
    logic                   ret_ack;

    row_t        rows[$];
    logic [15:0] lfsr_state;
    int          value_errors = 0;
    int          other_errors = 0;
    int          cycles = 0;
    int          cycle_limit = 0;

    pico_l15_bridge DUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .mem_valid      (mem_valid),
        .mem_addr       (mem_addr),
        .mem_wstrb      (mem_wstrb),
        .mem_wdata      (mem_wdata),
        .mem_amo_op     (mem_amo_op),
        .mem_ready      (mem_ready),
        .mem_rdata      (mem_rdata),
        .l15_val        (l15_val),
        .l15_req        (l15_req),
        .l15_ack        (l15_ack),
        .l15_header_ack (l15_header_ack),
        .ret_val        (ret_val),
        .l15_ret        (l15_ret),
        .ret_ack        (ret_ack)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // run limit scaled to the number of rows once the table is built
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            other_errors = other_errors + 1;
            report_counts();
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // galois lfsr x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 16'hb400;
        end
        return out;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_bit()};
        end
        return r;
    endfunction

    // core word to big endian byte order
    function automatic pico_l15_pkg::word_t reverse_bytes(input pico_l15_pkg::word_t w);
        pico_l15_pkg::word_t r;
        for (int b = 0; b < 4; b++) begin
            r[8*b +: 8] = w[8*(3-b) +: 8];
        end
        return r;
    endfunction

    // whole word, aligned halfword, single byte, else illegal
    function automatic pico_l15_pkg::size_t strobe_size(input pico_l15_pkg::wstrb_t s);
        if (s == 4'b1111) begin
            return pico_l15_pkg::SZ_4B;
        end else if (s == 4'b0011 || s == 4'b1100) begin
            return pico_l15_pkg::SZ_2B;
        end else if ((s & (s - 4'd1)) == 4'd0) begin
            return pico_l15_pkg::SZ_1B;
        end
        return 3'd0;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("FAIL %s: got %0h, expected %0h at %0t", name, got, exp, $time);
        value_errors = value_errors + 1;
    endtask

    task automatic check_rqtype(input string name, input pico_l15_pkg::rqtype_t got,
                                input pico_l15_pkg::rqtype_t exp);
        if (got !== exp)
            report_mismatch(name, got, exp);
    endtask

    task automatic check_amo_op(input string name, input pico_l15_pkg::amo_op_t got,
                                input pico_l15_pkg::amo_op_t exp);
        if (got !== exp)
            report_mismatch(name, got, exp);
    endtask

    task automatic check_size(input string name, input pico_l15_pkg::size_t got,
                              input pico_l15_pkg::size_t exp);
        if (got !== exp)
            report_mismatch(name, got, exp);
    endtask

    task automatic check_addr(input string name, input pico_l15_pkg::addr40_t got,
                              input pico_l15_pkg::addr40_t exp);
        if (got !== exp)
            report_mismatch(name, got, exp);
    endtask

    task automatic check_dword(input string name, input pico_l15_pkg::dword_t got,
                               input pico_l15_pkg::dword_t exp);
        if (got !== exp)
            report_mismatch(name, got, exp);
    endtask

    task automatic check_word(input string name, input pico_l15_pkg::word_t got,
                              input pico_l15_pkg::word_t exp);
        if (got !== exp)
            report_mismatch(name, got, exp);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_mismatch(name, got, exp);
    endtask

    task automatic report_counts();
        $display("value mismatches: %0d, other failures: %0d", value_errors, other_errors);
    endtask

    task automatic add_row(input pico_l15_pkg::addr32_t addr,
                           input pico_l15_pkg::wstrb_t wstrb,
                           input pico_l15_pkg::word_t wdata,
                           input pico_l15_pkg::amo_op_t amo_op,
                           input logic [3:0] ack_delay,
                           input logic [3:0] ret_delay,
                           input pico_l15_pkg::dword_t ret_data,
                           input pico_l15_pkg::rqtype_t exp_rqtype,
                           input pico_l15_pkg::size_t exp_size,
                           input pico_l15_pkg::addr40_t exp_addr,
                           input pico_l15_pkg::dword_t exp_data,
                           input logic exp_nc,
                           input pico_l15_pkg::word_t exp_rdata);
        rows.push_back({addr, wstrb, wdata, amo_op, ack_delay, ret_delay, ret_data,
                        exp_rqtype, exp_size, exp_addr, exp_data, exp_nc, exp_rdata});
    endtask

    `include "tb_vectors.svh"

    // random stores with expected fields built from the request rules
    task automatic add_random_rows();
        pico_l15_pkg::addr32_t addr;
        pico_l15_pkg::wstrb_t  strb;
        pico_l15_pkg::word_t   data;
        pico_l15_pkg::word_t   rev;
        pico_l15_pkg::dword_t  ret_data;
        logic [3:0]            ack_delay;
        logic [3:0]            ret_delay;
        for (int n = 0; n < RANDOM_ROWS; n++) begin
            addr = random_bits(30) << 2;
            strb = 4'(random_bits(4));
            if (strb == 4'b0000) begin
                strb = 4'b1111;
            end
            data      = random_bits(32);
            ack_delay = 4'(random_bits(2));
            ret_delay = 4'(random_bits(2));
            ret_data  = {random_bits(32), random_bits(32)};
            rev       = reverse_bytes(data);
            add_row(addr, strb, data, pico_l15_pkg::AMO_OP_NONE, ack_delay, ret_delay,
                    ret_data, pico_l15_pkg::RQ_STORE, strobe_size(strb),
                    {{8{addr[31]}}, addr}, {rev, rev}, addr[31], '0);
        end
    endtask

    // inputs change a little after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic drive_core(input row_t r);
        mem_valid  = 1'b1;
        mem_addr   = r.addr;
        mem_wstrb  = r.wstrb;
        mem_wdata  = r.wdata;
        mem_amo_op = r.amo_op;
    endtask

    task automatic check_request(input row_t r);
        check_rqtype("l15_req.rqtype", l15_req.rqtype, r.exp_rqtype);
        check_amo_op("l15_req.amo_op", l15_req.amo_op, r.amo_op);
        check_size("l15_req.size", l15_req.size, r.exp_size);
        check_addr("l15_req.address", l15_req.address, r.exp_addr);
        check_dword("l15_req.data", l15_req.data, r.exp_data);
        check_bit("l15_req.nc", l15_req.nc, r.exp_nc);
    endtask

    // one full access with request, ack after the delay, return and ready pulse
    task automatic run_row(input row_t r);
        next_cycle();
        drive_core(r);
        l15_ret.data = r.ret_data;
        l15_ret.rettype = (r.exp_rqtype == pico_l15_pkg::RQ_LOAD) ? pico_l15_pkg::RET_LOAD :
                          (r.exp_rqtype == pico_l15_pkg::RQ_AMO) ? pico_l15_pkg::RET_AMO :
                          pico_l15_pkg::RET_STORE_ACK;
        @(negedge clk);
        check_bit("l15_val before sampling", l15_val, 1'b0);
        // valid is up one edge later and the fields stay steady through the ack
        for (int i = 0; i <= r.ack_delay + 1; i++) begin
            next_cycle();
            l15_ack = (i == r.ack_delay + 1);
            @(negedge clk);
            check_bit("l15_val", l15_val, 1'b1);
            check_request(r);
        end
        // core still waits so valid must not come back
        for (int i = 0; i <= r.ret_delay; i++) begin
            next_cycle();
            l15_ack = 1'b0;
            ret_val = (i == r.ret_delay);
            @(negedge clk);
            check_bit("l15_val after ack", l15_val, 1'b0);
            check_bit("ret_ack", ret_ack, ret_val);
            check_bit("mem_ready", mem_ready, 1'b0);
        end
        next_cycle();
        ret_val = 1'b0;
        @(negedge clk);
        check_bit("mem_ready", mem_ready, 1'b1);
        check_word("mem_rdata", mem_rdata, r.exp_rdata);
        check_bit("ret_ack", ret_ack, 1'b0);
        // core saw ready and drops its request
        next_cycle();
        mem_valid = 1'b0;
        @(negedge clk);
        check_bit("mem_ready after pulse", mem_ready, 1'b0);
        check_bit("l15_val idle", l15_val, 1'b0);
        check_addr("l15_req.address idle", l15_req.address, '0);
    endtask

    // reset hits while the request waits for its ack
    task automatic reset_during_request(input row_t r);
        next_cycle();
        drive_core(r);
        next_cycle();
        @(negedge clk);
        check_bit("l15_val before reset", l15_val, 1'b1);
        next_cycle();
        rst_n = 1'b0;
        mem_valid = 1'b0;
        // a return seen only during reset must not show up as ready
        ret_val = 1'b1;
        repeat (3) next_cycle();
        rst_n = 1'b1;
        ret_val = 1'b0;
        @(negedge clk);
        check_bit("l15_val after reset", l15_val, 1'b0);
        check_bit("mem_ready after reset", mem_ready, 1'b0);
        check_bit("ret_ack after reset", ret_ack, 1'b0);
    endtask

    initial begin
        rst_n          = 1'b0;
        mem_valid      = 1'b0;
        mem_addr       = '0;
        mem_wstrb      = '0;
        mem_wdata      = '0;
        mem_amo_op     = '0;
        l15_ack        = 1'b0;
        l15_header_ack = 1'b0;
        ret_val        = 1'b0;
        l15_ret        = '0;
        lfsr_state     = 16'd12884;
        load_table();
        add_random_rows();
        // table rows plus the reset row and its replay
        cycle_limit = 20 * (rows.size() + 2) + 200;
        repeat (10) next_cycle();
        rst_n = 1'b1;
        for (int i = 0; i < rows.size(); i++) begin
            run_row(rows[i]);
        end
        reset_during_request(rows[1]);
        run_row(rows[1]);
        report_counts();
        if (value_errors == 0 && other_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+sim
source/pico_l15_pkg.sv
source/pico_request_decoder.sv
source/pico_request_tracker.sv
source/pico_response_encoder.sv
source/pico_l15_bridge.sv
sim/tb_pico_l15_bridge.sv
